//--- Makefile
TOP = ray_caster_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Testbench passed'

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module ray_caster

clean:
	rm -rf obj_dir

//--- build.f
source/geom_pkg.sv
source/trace_pkg.sv
source/tri_store.sv
source/tri_walker.sv
source/stage_buf.sv
source/edge_test.sv
source/nearest_hit.sv
source/ray_caster.sv
verif/ray_caster_tb.sv

//--- source/edge_test.sv
module edge_test (
  input  logic                                clk,
  input  logic                                rst,
  input  logic signed [geom_pkg::coord_w-1:0] ox,
  input  logic signed [geom_pkg::coord_w-1:0] oy,
  input  logic signed [geom_pkg::coord_w-1:0] oz,
  input  logic                                in_valid,
  output logic                                in_ready,
  input  logic [geom_pkg::tri_w-1:0]          in_tri,
  input  logic [trace_pkg::idx_w-1:0]         in_idx,
  input  logic                                in_last,
  output logic                                out_valid,
  input  logic                                out_ready,
  output logic                                out_hit,
  output logic signed [geom_pkg::depth_w-1:0] out_depth,
  output logic [trace_pkg::idx_w-1:0]         out_idx,
  output logic                                out_last
);
  import geom_pkg::*;
  import trace_pkg::*;

  logic [test_lat-1:0] vld;
  logic advance;
  logic signed [coord_w-1:0] vx [3];
  logic signed [coord_w-1:0] vy [3];
  logic signed [coord_w-1:0] v0z;
  logic signed [diff_w-1:0] s1_ex [3];    // bx - ax.
  logic signed [diff_w-1:0] s1_ey [3];    // by - ay.
  logic signed [diff_w-1:0] s1_px [3];    // px - ax.
  logic signed [diff_w-1:0] s1_py [3];    // py - ay.
  logic signed [depth_w-1:0] s1_depth;
  logic [idx_w-1:0] s1_idx;
  logic s1_last;
  logic signed [edge_w-1:0] s2_pa [3];
  logic signed [edge_w-1:0] s2_pb [3];
  logic signed [depth_w-1:0] s2_depth;
  logic [idx_w-1:0] s2_idx;
  logic s2_last;
  logic signed [edge_w-1:0] edge_val [3];
  logic all_ge;
  logic all_le;
  logic all_zero;

  assign vx[0] = in_tri[v0_lsb + x_off +: coord_w];
  assign vy[0] = in_tri[v0_lsb + y_off +: coord_w];
  assign vx[1] = in_tri[v1_lsb + x_off +: coord_w];
  assign vy[1] = in_tri[v1_lsb + y_off +: coord_w];
  assign vx[2] = in_tri[v2_lsb + x_off +: coord_w];
  assign vy[2] = in_tri[v2_lsb + y_off +: coord_w];
  assign v0z = in_tri[v0_lsb + z_off +: coord_w];    // Flat at the z of v0.

  assign out_valid = vld[test_lat-1];
  assign advance = !out_valid || out_ready;    // Whole pipe stalls together.
  assign in_ready = advance;

  always_comb begin
    all_ge = 1'b1;
    all_le = 1'b1;
    all_zero = 1'b1;
    for (int e = 0; e < 3; e++) begin
      edge_val[e] = s2_pa[e] - s2_pb[e];
      all_ge &= !edge_val[e][edge_w-1];
      all_le &= edge_val[e][edge_w-1] || (edge_val[e] == '0);
      all_zero &= (edge_val[e] == '0);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[test_lat-2:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int e = 0; e < 3; e++) begin
        s1_ex[e] <= vx[(e + 1) % 3] - vx[e];
        s1_ey[e] <= vy[(e + 1) % 3] - vy[e];
        s1_px[e] <= ox - vx[e];
        s1_py[e] <= oy - vy[e];
        s2_pa[e] <= s1_ex[e] * s1_py[e];
        s2_pb[e] <= s1_ey[e] * s1_px[e];
      end
      s1_depth <= v0z - oz;
      s1_idx <= in_idx;
      s1_last <= in_last;
      s2_depth <= s1_depth;
      s2_idx <= s1_idx;
      s2_last <= s1_last;
      out_hit <= (all_ge || all_le) && !all_zero &&
                 !s2_depth[depth_w-1] && (s2_depth != '0);
      out_depth <= s2_depth;
      out_idx <= s2_idx;
      out_last <= s2_last;
    end
  end

  // The walker holds the origin while beats of its ray arrive.
  a_origin_stable: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> $stable({ox, oy, oz}));

endmodule

//--- source/geom_pkg.sv
package geom_pkg;

  // Signed vertex and origin coordinate.
  localparam int coord_w = 16;

  // Difference of two coordinates, one bit wider so it never overflows.
  localparam int diff_w = coord_w + 1;

  // Depth is v0.z - oz.
  localparam int depth_w = coord_w + 1;

  // Difference of two products of coordinate differences.
  localparam int edge_w = 2 * diff_w;

  localparam int coords_per_vtx = 3;                 // x, y, z.
  localparam int vtx_w = coords_per_vtx * coord_w;
  localparam int tri_w = 3 * vtx_w;                  // Three vertices.

  // Vertex slots inside a stored triangle, v0 in the low bits.
  localparam int v0_lsb = 0;
  localparam int v1_lsb = vtx_w;
  localparam int v2_lsb = 2 * vtx_w;

  // Coordinate slots inside a vertex.
  localparam int x_off = 0;
  localparam int y_off = coord_w;
  localparam int z_off = 2 * coord_w;

endpackage

//--- source/nearest_hit.sv
module nearest_hit (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                in_valid,
  output logic                                in_ready,
  input  logic                                in_hit,
  input  logic signed [geom_pkg::depth_w-1:0] in_depth,
  input  logic [trace_pkg::idx_w-1:0]         in_idx,
  input  logic                                in_last,
  output logic                                result_valid,
  input  logic                                result_ready,
  output logic                                result_hit,
  output logic [trace_pkg::idx_w-1:0]         result_idx,
  output logic signed [geom_pkg::depth_w-1:0] result_depth,
  output logic                                done
);
  import geom_pkg::*;
  import trace_pkg::*;

  logic take;
  logic fresh;      // Next item starts a new ray.
  logic better;
  logic load;
  logic best_hit;
  logic signed [depth_w-1:0] best_depth;
  logic [idx_w-1:0] best_idx;

  assign in_ready = !result_valid;
  assign take = in_valid && in_ready;
  assign better = in_hit && (!best_hit || in_depth < best_depth);    // Ties keep the earlier.
  assign load = take && (fresh || better);

  assign result_hit = best_hit;
  assign result_idx = best_hit ? best_idx : '0;
  assign result_depth = best_hit ? best_depth : '0;
  assign done = result_valid && result_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result_valid <= 1'b0;
      fresh <= 1'b1;
      best_hit <= 1'b0;
    end else begin
      if (take) begin
        fresh <= in_last;
        if (in_last) result_valid <= 1'b1;
      end else if (done) begin
        result_valid <= 1'b0;
      end
      if (load) best_hit <= in_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      best_depth <= in_depth;
      best_idx <= in_idx;
    end
  end

  // One ray at a time, so nothing follows the last item until done.
  a_drained_while_result: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> !in_valid);

endmodule

//--- source/ray_caster.sv
module ray_caster (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                tri_we,
  input  logic [trace_pkg::idx_w-1:0]         tri_waddr,
  input  logic [geom_pkg::tri_w-1:0]          tri_wdata,
  input  logic                                ray_valid,
  output logic                                ray_ready,
  input  logic signed [geom_pkg::coord_w-1:0] ox,
  input  logic signed [geom_pkg::coord_w-1:0] oy,
  input  logic signed [geom_pkg::coord_w-1:0] oz,
  input  logic [trace_pkg::idx_w-1:0]         first,
  input  logic [trace_pkg::idx_w:0]           count,
  output logic                                result_valid,
  input  logic                                result_ready,
  output logic                                result_hit,
  output logic [trace_pkg::idx_w-1:0]         result_idx,
  output logic signed [geom_pkg::depth_w-1:0] result_depth
);
  import geom_pkg::*;
  import trace_pkg::*;

  typedef struct packed {
    logic [tri_w-1:0] tri_data;
    logic [idx_w-1:0] idx;
    logic             last;
  } tri_item_t;

  typedef struct packed {
    logic                      hit;
    logic signed [depth_w-1:0] depth;
    logic [idx_w-1:0]          idx;
    logic                      last;
  } hit_item_t;

  logic [idx_w-1:0] rd_addr;
  logic [tri_w-1:0] rd_data;
  logic signed [coord_w-1:0] ray_ox, ray_oy, ray_oz;
  logic walk_valid, walk_ready, walk_last;
  logic [tri_w-1:0] walk_tri;
  logic [idx_w-1:0] walk_idx;
  tri_item_t walk_item, tb_item;
  logic tb_valid, tb_ready;
  logic hit_valid, hit_ready, hit_flag, hit_last;
  logic signed [depth_w-1:0] hit_depth;
  logic [idx_w-1:0] hit_idx;
  hit_item_t hit_item, hb_item;
  logic hb_valid, hb_ready;
  logic done;

  assign walk_item.tri_data = walk_tri;
  assign walk_item.idx = walk_idx;
  assign walk_item.last = walk_last;
  assign hit_item.hit = hit_flag;
  assign hit_item.depth = hit_depth;
  assign hit_item.idx = hit_idx;
  assign hit_item.last = hit_last;

  tri_store u_store (
    .clk(clk), .tri_we(tri_we), .tri_waddr(tri_waddr), .tri_wdata(tri_wdata),
    .raddr(rd_addr), .rdata(rd_data)
  );

  tri_walker u_walker (
    .clk(clk), .rst(rst), .ray_valid(ray_valid), .ray_ready(ray_ready),
    .ox(ox), .oy(oy), .oz(oz), .first(first), .count(count), .done(done),
    .raddr(rd_addr), .rdata(rd_data),
    .out_valid(walk_valid), .out_ready(walk_ready), .out_tri(walk_tri),
    .out_idx(walk_idx), .out_last(walk_last),
    .ray_ox(ray_ox), .ray_oy(ray_oy), .ray_oz(ray_oz)
  );

  stage_buf #(.payload_t(tri_item_t)) u_tri_buf (
    .clk(clk), .rst(rst),
    .in_valid(walk_valid), .in_ready(walk_ready), .in_data(walk_item),
    .out_valid(tb_valid), .out_ready(tb_ready), .out_data(tb_item)
  );

  edge_test u_test (
    .clk(clk), .rst(rst), .ox(ray_ox), .oy(ray_oy), .oz(ray_oz),
    .in_valid(tb_valid), .in_ready(tb_ready), .in_tri(tb_item.tri_data),
    .in_idx(tb_item.idx), .in_last(tb_item.last),
    .out_valid(hit_valid), .out_ready(hit_ready), .out_hit(hit_flag),
    .out_depth(hit_depth), .out_idx(hit_idx), .out_last(hit_last)
  );

  stage_buf #(.payload_t(hit_item_t)) u_hit_buf (
    .clk(clk), .rst(rst),
    .in_valid(hit_valid), .in_ready(hit_ready), .in_data(hit_item),
    .out_valid(hb_valid), .out_ready(hb_ready), .out_data(hb_item)
  );

  nearest_hit u_nearest (
    .clk(clk), .rst(rst),
    .in_valid(hb_valid), .in_ready(hb_ready), .in_hit(hb_item.hit),
    .in_depth(hb_item.depth), .in_idx(hb_item.idx), .in_last(hb_item.last),
    .result_valid(result_valid), .result_ready(result_ready), .result_hit(result_hit),
    .result_idx(result_idx), .result_depth(result_depth), .done(done)
  );

endmodule

//--- source/stage_buf.sv
module stage_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t mem [2];
  logic wr_ptr;
  logic rd_ptr;
  logic [1:0] used;
  logic push;
  logic pop;

  assign in_ready = (used != 2'd2);    // Depends on state only.
  assign out_valid = (used != 2'd0);
  assign out_data = mem[rd_ptr];
  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      used <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      used <= used + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Upstream keeps its beat while the buffer is full.
  a_hold_full: assert property (@(posedge clk) disable iff (rst)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

//--- source/trace_pkg.sv
package trace_pkg;

  // Triangle slots in the store.
  localparam int num_tri = 64;

  localparam int idx_w = $clog2(num_tri);    // Triangle index.

  // Register stages in the edge test pipeline.
  localparam int test_lat = 3;

endpackage

//--- source/tri_store.sv
module tri_store (
  input  logic                          clk,
  input  logic                          tri_we,
  input  logic [trace_pkg::idx_w-1:0]   tri_waddr,
  input  logic [geom_pkg::tri_w-1:0]    tri_wdata,
  input  logic [trace_pkg::idx_w-1:0]   raddr,
  output logic [geom_pkg::tri_w-1:0]    rdata
);
  import trace_pkg::*;

  logic [geom_pkg::tri_w-1:0] mem [num_tri];

  always_ff @(posedge clk) begin
    if (tri_we) begin
      mem[tri_waddr] <= tri_wdata;
    end
  end

  assign rdata = mem[raddr];    // Same-cycle read for the walker.

endmodule

//--- source/tri_walker.sv
module tri_walker (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                ray_valid,
  output logic                                ray_ready,
  input  logic signed [geom_pkg::coord_w-1:0] ox,
  input  logic signed [geom_pkg::coord_w-1:0] oy,
  input  logic signed [geom_pkg::coord_w-1:0] oz,
  input  logic [trace_pkg::idx_w-1:0]         first,
  input  logic [trace_pkg::idx_w:0]           count,
  input  logic                                done,
  output logic [trace_pkg::idx_w-1:0]         raddr,
  input  logic [geom_pkg::tri_w-1:0]          rdata,
  output logic                                out_valid,
  input  logic                                out_ready,
  output logic [geom_pkg::tri_w-1:0]          out_tri,
  output logic [trace_pkg::idx_w-1:0]         out_idx,
  output logic                                out_last,
  output logic signed [geom_pkg::coord_w-1:0] ray_ox,
  output logic signed [geom_pkg::coord_w-1:0] ray_oy,
  output logic signed [geom_pkg::coord_w-1:0] ray_oz
);
  import trace_pkg::*;

  typedef enum logic [1:0] {st_idle, st_walk, st_wait} state_t;

  state_t state, state_next;
  logic [idx_w-1:0] idx_q;
  logic [idx_w:0] remain_q;     // Beats still to send.
  logic ray_take;
  logic beat_take;

  assign ray_take = ray_valid && ray_ready;
  assign beat_take = out_valid && out_ready;

  assign raddr = idx_q;
  assign out_valid = (state == st_walk);
  assign out_tri = rdata;
  assign out_idx = idx_q;
  assign out_last = (remain_q == 1);

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (ray_take) state_next = st_walk;
      st_walk: if (beat_take && out_last) state_next = st_wait;
      st_wait: if (done) state_next = st_idle;    // Result taken downstream.
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
      ray_ready <= 1'b0;
      idx_q <= '0;
      remain_q <= '0;
    end else begin
      state <= state_next;
      ray_ready <= (state_next == st_idle);
      if (ray_take) begin
        idx_q <= first;
        remain_q <= count;
      end else if (beat_take) begin
        idx_q <= idx_q + 1'b1;
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ray_take) begin
      ray_ox <= ox;
      ray_oy <= oy;
      ray_oz <= oz;
    end
  end

  a_count_range: assert property (@(posedge clk) disable iff (rst)
    ray_take |-> (count != 0 && count <= num_tri));

endmodule

//--- verif/ray_caster_tb.sv
module ray_caster_tb;
  import geom_pkg::*;
  import trace_pkg::*;

  localparam int tri_count = 8;
  localparam int ray_count = 11;
  localparam int max_cycles = ray_count * (num_tri + test_lat + 10) * 4;

  logic clk;
  logic rst;
  logic tri_we;
  logic [idx_w-1:0] tri_waddr;
  logic [tri_w-1:0] tri_wdata;
  logic ray_valid;
  logic ray_ready;
  logic signed [coord_w-1:0] ox;
  logic signed [coord_w-1:0] oy;
  logic signed [coord_w-1:0] oz;
  logic [idx_w-1:0] first;
  logic [idx_w:0] count;
  logic result_valid;
  logic result_ready = 1'b0;
  logic result_hit;
  logic [idx_w-1:0] result_idx;
  logic signed [depth_w-1:0] result_depth;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int rays_sent = 0;        // Rays accepted by the DUT.
  int results_taken = 0;    // Results accepted from the DUT.
  logic [31:0] lfsr = 32'hd5a1_14fd;

  // Each row is v0 x y z, v1 x y z, v2 x y z.
  int tri_tab [tri_count][9] = '{
    '{  0,   0,  10,  10,   0,  10,   0,  10,  10},    // Counter-clockwise.
    '{  0,   0,   5,   0,  10,   5,  10,   0,   5},    // Nearer clockwise copy.
    '{  0,   0,   5,  10,   0,   5,   0,  10,   5},    // Same depth as the clockwise copy.
    '{  0,   0,  -3,  10,   0,  -3,   0,  10,  -3},    // Behind the origin.
    '{  0,   0,   7,   5,   5,   7,  10,  10,   7},    // Degenerate line.
    '{100, 100,  20, 110, 100,  20, 100, 110,  20},    // Far away.
    '{-50, -50,  30,  50, -50,  30,   0,  50,  30},    // Large.
    '{-20, -20,   8, -10, -20,   8, -20, -10,   8}     // Negative corner.
  };

  // Each row is ox, oy, oz, first, count, then expected hit, index and depth.
  int ray_tab [ray_count][8] = '{
    '{  2,   2,    0, 0, 1, 1, 0,  10},    // Inside one triangle.
    '{ 20,  20,    0, 0, 1, 0, 0,   0},    // Outside all edges.
    '{  2,   2,    0, 3, 1, 0, 0,   0},
    '{  2,   2,    0, 0, 3, 1, 1,   5},    // Nearest wins and the tie keeps the lower index.
    '{  5,   0,    0, 0, 1, 1, 0,  10},    // On an edge.
    '{  5,   5,    0, 4, 1, 0, 0,   0},
    '{  0,   0,    0, 0, 8, 1, 1,   5},    // Whole table with the origin on vertices.
    '{-18, -18,   -2, 5, 3, 1, 7,  10},    // Later triangle is closer.
    '{105, 102,   25, 5, 1, 0, 0,   0},    // Negative depth.
    '{  3,   3, -100, 6, 1, 1, 6, 130},
    '{  2,   2,    5, 1, 1, 0, 0,   0}     // Zero depth.
  };

  ray_caster dut (
    .clk(clk), .rst(rst),
    .tri_we(tri_we), .tri_waddr(tri_waddr), .tri_wdata(tri_wdata),
    .ray_valid(ray_valid), .ray_ready(ray_ready),
    .ox(ox), .oy(oy), .oz(oz), .first(first), .count(count),
    .result_valid(result_valid), .result_ready(result_ready),
    .result_hit(result_hit), .result_idx(result_idx), .result_depth(result_depth)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32, 22, 2, 1.
  endfunction

  function automatic logic [tri_w-1:0] pack_tri(input int t);
    logic [tri_w-1:0] data;
    data = '0;
    for (int k = 0; k < 9; k++) begin
      data[k*coord_w +: coord_w] = coord_w'(tri_tab[t][k]);    // v0.x lowest.
    end
    return data;
  endfunction

  task automatic compare_value(input string name, input int got, input int expected);
    checks++;
    assert (got == expected) else begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("At time %0t: %s", $time, what);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d results received",
               cycles, results_taken, ray_count);
      $display("Testbench failed");
      $finish;
    end
  end

  // Random back-pressure and result checks.
  always @(negedge clk) begin
    if (!rst) begin
      lfsr = lfsr_step(lfsr);
      result_ready = lfsr[0];
      if (rays_sent != results_taken) begin
        require(!ray_ready, "ray_ready went high while a ray was still in flight");
      end
      if (result_valid && result_ready) begin
        if (results_taken >= rays_sent) begin
          require(1'b0, "a result was delivered with no ray outstanding");
        end else begin
          compare_value("result_hit", result_hit, ray_tab[results_taken][5]);
          compare_value("result_idx", result_idx, ray_tab[results_taken][6]);
          compare_value("result_depth", result_depth, ray_tab[results_taken][7]);
        end
        results_taken <= results_taken + 1;
      end
    end
  end

  initial begin
    rst = 1'b1;
    tri_we = 1'b0;
    tri_waddr = '0;
    tri_wdata = '0;
    ray_valid = 1'b0;
    ox = '0;
    oy = '0;
    oz = '0;
    first = '0;
    count = '0;
    repeat (4) begin
      @(negedge clk);
      require(!result_valid && !ray_ready, "result_valid or ray_ready high in reset");
    end
    rst <= 1'b0;

    for (int t = 0; t < tri_count; t++) begin
      tri_we = 1'b1;
      tri_waddr = idx_w'(t);
      tri_wdata = pack_tri(t);
      @(negedge clk);
    end
    tri_we = 1'b0;

    for (int r = 0; r < ray_count; r++) begin
      ray_valid = 1'b1;
      ox = coord_w'(ray_tab[r][0]);
      oy = coord_w'(ray_tab[r][1]);
      oz = coord_w'(ray_tab[r][2]);
      first = idx_w'(ray_tab[r][3]);
      count = (idx_w + 1)'(ray_tab[r][4]);
      while (!ray_ready) @(negedge clk);
      rays_sent <= rays_sent + 1;    // Taken on the coming rising edge.
      @(negedge clk);
      ray_valid = 1'b0;
      require(!ray_ready, "ray_ready stayed high after a ray was accepted");
    end

    while (results_taken < ray_count) @(negedge clk);
    repeat (test_lat + 10) @(negedge clk);
    require(!result_valid, "result_valid high after the last result was taken");
    compare_value("results_taken", results_taken, ray_count);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
